/* hw/bwt_pkg.sv */
// BWT backward extension shared types
// widths, latencies and the per-byte symbol count used by the occurrence counters

package bwt_pkg;

	// ----------------------------------------
	// widths
	// ----------------------------------------

	// BWT position or interval field
	typedef logic [63:0] bwt_pos_t;

	// occurrence count of one symbol
	typedef logic [31:0] occ_t;

	// 32 packed 2-bit symbols
	typedef logic [63:0] bwt_word_t;

	// four 8-bit per-symbol counts, symbol 0 in the low byte
	typedef logic [31:0] sym_counts_t;

	// status tag carried with each item
	typedef logic [5:0] status_t;

	// DNA symbol or query code
	typedef logic [1:0] sym_t;

	// ----------------------------------------
	// constants
	// ----------------------------------------

	localparam int N_SYM = 4;

	// pipeline depth of one occurrence counter
	localparam int OCC_LATENCY = 7;

	// pipeline depth of the interval merge
	localparam int MERGE_LATENCY = 5;

	localparam status_t STATUS_BUBBLE = 6'b00_0000;

	// ----------------------------------------
	// symbol count of one byte
	// ----------------------------------------

	// counts of each symbol among the four pairs of a byte
	function automatic sym_counts_t byte_sym_count(input logic [7:0] b);
		sym_counts_t cnt;
		sym_t s;
		cnt = '0;
		for (int i = 0; i < 4; i++) begin
			s = b[2*i +: 2];
			cnt[8*s +: 8] = cnt[8*s +: 8] + 8'd1;
		end
		return cnt;
	endfunction

endpackage

/* hw/interval_if.sv */
// delayed bi-interval bundle
// carries the interval and its tag from the delay line into the merge stage

interface interval_if;

	bwt_pkg::bwt_pos_t x0;
	bwt_pkg::bwt_pos_t x1;
	bwt_pkg::bwt_pos_t x2;
	// precomputed upper bound plus one
	bwt_pkg::bwt_pos_t x1_plus_x2;
	bwt_pkg::status_t status;

	modport src (
		output x0, x1, x2, x1_plus_x2, status
	);

	modport dst (
		input x0, x1, x2, x1_plus_x2, status
	);

endinterface

/* hw/bwt_occ4.sv */
// occurrence counter for one BWT position
// counts the four symbols up to pos inside a 128-symbol block, seven stages

module bwt_occ4 (
	input  logic              Clk_32UI,
	input  logic              stall,
	input  bwt_pkg::bwt_pos_t pos,
	input  bwt_pkg::occ_t     occ_base [bwt_pkg::N_SYM],
	input  bwt_pkg::bwt_word_t occ_words [bwt_pkg::N_SYM],
	output bwt_pkg::occ_t     occ [bwt_pkg::N_SYM]
);

	localparam int CARRY = bwt_pkg::OCC_LATENCY - 1;

	// position bits and base counts ride along with the sums
	logic [6:0] pos_q [1:CARRY];
	bwt_pkg::occ_t base_q [1:CARRY][bwt_pkg::N_SYM];

	logic [31:0] mask;
	logic [31:0] sel_half;
	// slot 0 is the masked half, slots 1..7 are halves 0..6
	logic [31:0] half_q [8];

	bwt_pkg::sym_counts_t pair_q [8][2];
	bwt_pkg::sym_counts_t half_cnt_q [8];
	bwt_pkg::sym_counts_t tot2_q [4];
	bwt_pkg::sym_counts_t odd_q [4];
	bwt_pkg::sym_counts_t pre_q [8];
	bwt_pkg::sym_counts_t sel_q;
	bwt_pkg::sym_counts_t adj;

	// keep pairs 0..pos[3:0] counted from the top, zero the rest
	always_comb begin
		mask = ~((32'd1 << {~pos[3:0], 1'b0}) - 32'd1);
		sel_half = occ_words[pos[6:5]][32*pos[4] +: 32];
	end

	// ----------------------------------------
	// stage 1: select and mask
	// ----------------------------------------
	always_ff @(posedge Clk_32UI) begin
		if (!stall) begin
			half_q[0] <= sel_half & mask;
			for (int i = 0; i < 7; i++) begin
				half_q[i+1] <= occ_words[i/2][32*(i%2) +: 32];
			end
			pos_q[1] <= pos[6:0];
			base_q[1] <= occ_base;
		end
	end

	// ----------------------------------------
	// stages 2..5: byte counts and adder tree
	// ----------------------------------------
	always_ff @(posedge Clk_32UI) begin
		if (!stall) begin
			for (int h = 0; h < 8; h++) begin
				pair_q[h][0] <= bwt_pkg::byte_sym_count(half_q[h][7:0])
					+ bwt_pkg::byte_sym_count(half_q[h][15:8]);
				pair_q[h][1] <= bwt_pkg::byte_sym_count(half_q[h][23:16])
					+ bwt_pkg::byte_sym_count(half_q[h][31:24]);
				half_cnt_q[h] <= pair_q[h][0] + pair_q[h][1];
			end

			for (int g = 0; g < 4; g++) begin
				tot2_q[g] <= half_cnt_q[2*g] + half_cnt_q[2*g+1];
				odd_q[g] <= half_cnt_q[2*g];
			end

			// running sums inside each group of four halves
			pre_q[0] <= odd_q[0];
			pre_q[1] <= tot2_q[0];
			pre_q[2] <= tot2_q[0] + odd_q[1];
			pre_q[3] <= tot2_q[0] + tot2_q[1];
			pre_q[4] <= odd_q[2];
			pre_q[5] <= tot2_q[2];
			pre_q[6] <= tot2_q[2] + odd_q[3];
			pre_q[7] <= tot2_q[2] + tot2_q[3];

			for (int s = 2; s <= CARRY; s++) begin
				pos_q[s] <= pos_q[s-1];
				base_q[s] <= base_q[s-1];
			end
		end
	end

	// ----------------------------------------
	// stage 6: pick the prefix for the half index
	// ----------------------------------------
	always_ff @(posedge Clk_32UI) begin
		if (!stall) begin
			if (pos_q[5][6]) begin
				sel_q <= pre_q[3] + pre_q[pos_q[5][6:4]];
			end else begin
				sel_q <= pre_q[pos_q[5][6:4]];
			end
		end
	end

	// masked pairs were counted as symbol 0, take them back out
	assign adj = sel_q - {28'd0, ~pos_q[CARRY][3:0]};

	// ----------------------------------------
	// stage 7: add the block base counts
	// ----------------------------------------
	always_ff @(posedge Clk_32UI) begin
		if (!stall) begin
			for (int c = 0; c < bwt_pkg::N_SYM; c++) begin
				occ[c] <= base_q[CARRY][c] + {24'd0, adj[8*c +: 8]};
			end
		end
	end

endmodule

/* hw/interval_delay.sv */
// bi-interval delay line
// holds the interval and tag until the occurrence counts catch up

module interval_delay #(
	parameter int DEPTH = 7
) (
	input  logic              Clk_32UI,
	input  logic              reset_BWT_extend,
	input  logic              stall,
	input  bwt_pkg::bwt_pos_t ik_x0,
	input  bwt_pkg::bwt_pos_t ik_x1,
	input  bwt_pkg::bwt_pos_t ik_x2,
	input  bwt_pkg::status_t  status,
	interval_if.src           iv
);

	bwt_pkg::bwt_pos_t x0_q [DEPTH];
	bwt_pkg::bwt_pos_t x1_q [DEPTH];
	bwt_pkg::bwt_pos_t x2_q [DEPTH];
	bwt_pkg::status_t status_q [DEPTH];
	bwt_pkg::bwt_pos_t sum_q;

	// input of the last stage
	bwt_pkg::bwt_pos_t tail_x1;
	bwt_pkg::bwt_pos_t tail_x2;

	if (DEPTH == 1) begin : g_direct
		assign tail_x1 = ik_x1;
		assign tail_x2 = ik_x2;
	end else begin : g_chain
		assign tail_x1 = x1_q[DEPTH-2];
		assign tail_x2 = x2_q[DEPTH-2];
	end

	always_ff @(posedge Clk_32UI) begin
		if (!stall) begin
			x0_q[0] <= ik_x0;
			x1_q[0] <= ik_x1;
			x2_q[0] <= ik_x2;
			for (int i = 1; i < DEPTH; i++) begin
				x0_q[i] <= x0_q[i-1];
				x1_q[i] <= x1_q[i-1];
				x2_q[i] <= x2_q[i-1];
			end
			// upper bound for the sentinel test downstream
			sum_q <= tail_x1 + tail_x2;
		end
	end

	// tag stages
	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			for (int i = 0; i < DEPTH; i++) begin
				status_q[i] <= bwt_pkg::STATUS_BUBBLE;
			end
		end else if (!stall) begin
			status_q[0] <= status;
			for (int i = 1; i < DEPTH; i++) begin
				status_q[i] <= status_q[i-1];
			end
		end
	end

	assign iv.x0 = x0_q[DEPTH-1];
	assign iv.x1 = x1_q[DEPTH-1];
	assign iv.x2 = x2_q[DEPTH-1];
	assign iv.x1_plus_x2 = sum_q;
	assign iv.status = status_q[DEPTH-1];

endmodule

/* hw/interval_merge.sv */
// interval merge stage
// builds the four extended intervals and the query target over five stages

module interval_merge (
	input  logic              Clk_32UI,
	input  logic              reset_BWT_extend,
	input  logic              stall,
	input  bwt_pkg::bwt_pos_t primary,
	input  bwt_pkg::bwt_pos_t l2 [bwt_pkg::N_SYM],
	input  bwt_pkg::occ_t     occ_k [bwt_pkg::N_SYM],
	input  bwt_pkg::occ_t     occ_l [bwt_pkg::N_SYM],
	input  bwt_pkg::sym_t     query,
	interval_if.dst           iv,
	output bwt_pkg::bwt_pos_t ok_x0 [bwt_pkg::N_SYM],
	output bwt_pkg::bwt_pos_t ok_x1 [bwt_pkg::N_SYM],
	output bwt_pkg::bwt_pos_t ok_x2 [bwt_pkg::N_SYM],
	output bwt_pkg::bwt_pos_t ok_target_x0,
	output bwt_pkg::bwt_pos_t ok_target_x1,
	output bwt_pkg::bwt_pos_t ok_target_x2,
	output bwt_pkg::status_t  status_out
);

	localparam int LAST = bwt_pkg::MERGE_LATENCY - 1;

	bwt_pkg::bwt_pos_t x1_s [1:LAST][bwt_pkg::N_SYM];
	bwt_pkg::bwt_pos_t x2_s [1:LAST][bwt_pkg::N_SYM];
	bwt_pkg::status_t status_s [1:LAST];

	// x0 chain, one more symbol resolved per stage
	bwt_pkg::bwt_pos_t x0_s1;
	bwt_pkg::bwt_pos_t x0_s2;
	bwt_pkg::bwt_pos_t x0_s3 [2:3];
	bwt_pkg::bwt_pos_t x0_s4 [1:3];
	logic in_lo;
	logic in_hi;

	bwt_pkg::bwt_pos_t x0_next [bwt_pkg::N_SYM];
	bwt_pkg::sym_t sel;

	// ----------------------------------------
	// stages 1..4
	// ----------------------------------------
	always_ff @(posedge Clk_32UI) begin
		if (!stall) begin
			for (int c = 0; c < bwt_pkg::N_SYM; c++) begin
				x2_s[1][c] <= bwt_pkg::bwt_pos_t'(occ_l[c]) - bwt_pkg::bwt_pos_t'(occ_k[c]);
				x1_s[1][c] <= l2[c] + bwt_pkg::bwt_pos_t'(occ_k[c]) + 64'd1;
			end
			// sentinel inside [x1, x1+x2-1], empty interval holds none
			in_lo <= (iv.x1 <= primary);
			in_hi <= (iv.x2 != '0) && (iv.x1_plus_x2 - 64'd1 >= primary);
			x0_s1 <= iv.x0;

			for (int s = 2; s <= LAST; s++) begin
				x1_s[s] <= x1_s[s-1];
				x2_s[s] <= x2_s[s-1];
			end

			x0_s2 <= x0_s1 + {63'd0, in_lo & in_hi};
			x0_s3[3] <= x0_s2;
			x0_s3[2] <= x0_s2 + x2_s[2][3];
			x0_s4[3] <= x0_s3[3];
			x0_s4[2] <= x0_s3[2];
			x0_s4[1] <= x0_s3[2] + x2_s[3][2];
		end
	end

	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			for (int s = 1; s <= LAST; s++) begin
				status_s[s] <= bwt_pkg::STATUS_BUBBLE;
			end
			status_out <= bwt_pkg::STATUS_BUBBLE;
		end else if (!stall) begin
			status_s[1] <= iv.status;
			for (int s = 2; s <= LAST; s++) begin
				status_s[s] <= status_s[s-1];
			end
			status_out <= status_s[LAST];
		end
	end

	// last link of the chain feeds both the outputs and the target
	always_comb begin
		x0_next[0] = x0_s4[1] + x2_s[LAST][1];
		x0_next[1] = x0_s4[1];
		x0_next[2] = x0_s4[2];
		x0_next[3] = x0_s4[3];
	end

	// query 0 picks symbol 3
	assign sel = 2'd3 - query;

	// ----------------------------------------
	// stage 5: outputs
	// ----------------------------------------
	always_ff @(posedge Clk_32UI) begin
		if (!stall) begin
			for (int c = 0; c < bwt_pkg::N_SYM; c++) begin
				ok_x0[c] <= x0_next[c];
				ok_x1[c] <= x1_s[LAST][c];
				ok_x2[c] <= x2_s[LAST][c];
			end
			ok_target_x0 <= x0_next[sel];
			ok_target_x1 <= x1_s[LAST][sel];
			ok_target_x2 <= x2_s[LAST][sel];
		end
	end

endmodule

/* hw/bwt_extend.sv */
// BWT backward extension top level
// two occurrence counters, interval delay line and merge stage

module bwt_extend (
	input  logic               Clk_32UI,
	input  logic               reset_BWT_extend,
	input  logic               stall,
	input  bwt_pkg::status_t   status,
	input  bwt_pkg::bwt_pos_t  primary,
	input  bwt_pkg::bwt_pos_t  k,
	input  bwt_pkg::bwt_pos_t  l,
	input  bwt_pkg::occ_t      occ_base_k [bwt_pkg::N_SYM],
	input  bwt_pkg::occ_t      occ_base_l [bwt_pkg::N_SYM],
	input  bwt_pkg::bwt_word_t occ_words_k [bwt_pkg::N_SYM],
	input  bwt_pkg::bwt_word_t occ_words_l [bwt_pkg::N_SYM],
	input  bwt_pkg::bwt_pos_t  l2 [bwt_pkg::N_SYM],
	input  bwt_pkg::bwt_pos_t  ik_x0,
	input  bwt_pkg::bwt_pos_t  ik_x1,
	input  bwt_pkg::bwt_pos_t  ik_x2,
	input  bwt_pkg::sym_t      query,
	output bwt_pkg::bwt_pos_t  ok_x0 [bwt_pkg::N_SYM],
	output bwt_pkg::bwt_pos_t  ok_x1 [bwt_pkg::N_SYM],
	output bwt_pkg::bwt_pos_t  ok_x2 [bwt_pkg::N_SYM],
	output bwt_pkg::bwt_pos_t  ok_target_x0,
	output bwt_pkg::bwt_pos_t  ok_target_x1,
	output bwt_pkg::bwt_pos_t  ok_target_x2,
	output bwt_pkg::status_t   status_out
);

	bwt_pkg::occ_t cnt_k [bwt_pkg::N_SYM];
	bwt_pkg::occ_t cnt_l [bwt_pkg::N_SYM];

	interval_if iv ();

	// ----------------------------------------
	// occurrence counts at k and l
	// ----------------------------------------
	bwt_occ4 occ_k (
		.Clk_32UI  (Clk_32UI),
		.stall     (stall),
		.pos       (k),
		.occ_base  (occ_base_k),
		.occ_words (occ_words_k),
		.occ       (cnt_k)
	);

	bwt_occ4 occ_l (
		.Clk_32UI  (Clk_32UI),
		.stall     (stall),
		.pos       (l),
		.occ_base  (occ_base_l),
		.occ_words (occ_words_l),
		.occ       (cnt_l)
	);

	// interval waits out the counter latency
	interval_delay #(
		.DEPTH (bwt_pkg::OCC_LATENCY)
	) delay_line (
		.Clk_32UI         (Clk_32UI),
		.reset_BWT_extend (reset_BWT_extend),
		.stall            (stall),
		.ik_x0            (ik_x0),
		.ik_x1            (ik_x1),
		.ik_x2            (ik_x2),
		.status           (status),
		.iv               (iv.src)
	);

	interval_merge merge (
		.Clk_32UI         (Clk_32UI),
		.reset_BWT_extend (reset_BWT_extend),
		.stall            (stall),
		.primary          (primary),
		.l2               (l2),
		.occ_k            (cnt_k),
		.occ_l            (cnt_l),
		.query            (query),
		.iv               (iv.dst),
		.ok_x0            (ok_x0),
		.ok_x1            (ok_x1),
		.ok_x2            (ok_x2),
		.ok_target_x0     (ok_target_x0),
		.ok_target_x1     (ok_target_x1),
		.ok_target_x2     (ok_target_x2),
		.status_out       (status_out)
	);

endmodule

/* dv/bwt_extend_model.svh */
// reference model for the BWT backward extension
// occurrence counts and extended interval rules, written from the search rules

`ifndef BWT_EXTEND_MODEL_SVH
`define BWT_EXTEND_MODEL_SVH

// base count plus matching symbols up to pos inside the 128-symbol block
// half-word pos[6:4], symbols read from the top pair down
function automatic bwt_pkg::occ_t count_occ(input logic [255:0] blk, input bwt_pkg::occ_t base,
		input bwt_pkg::bwt_pos_t pos, input int c);
	int last;
	int n;
	last = 16 * int'(pos[6:4]) + int'(pos[3:0]);
	n = 0;
	for (int j = 0; j <= last; j++) begin
		if (blk[32*(j/16) + 30 - 2*(j%16) +: 2] == c[1:0]) begin
			n++;
		end
	end
	return base + bwt_pkg::occ_t'(n);
endfunction

// sentinel test, empty interval never holds it
function automatic bit holds_primary(input bwt_pkg::bwt_pos_t x1, input bwt_pkg::bwt_pos_t x2,
		input bwt_pkg::bwt_pos_t primary);
	return (primary >= x1) && (primary < x1 + x2);
endfunction

// size of the extended interval
function automatic bwt_pkg::bwt_pos_t extend_x2(input bwt_pkg::occ_t occ_l,
		input bwt_pkg::occ_t occ_k);
	return bwt_pkg::bwt_pos_t'(occ_l) - bwt_pkg::bwt_pos_t'(occ_k);
endfunction

// start of the extended interval
function automatic bwt_pkg::bwt_pos_t extend_x1(input bwt_pkg::bwt_pos_t l2,
		input bwt_pkg::occ_t occ_k);
	return l2 + bwt_pkg::bwt_pos_t'(occ_k) + 64'd1;
endfunction

`endif

/* dv/tb_bwt_extend.sv */
// testbench for the BWT backward extension
// random items under random stall checked against the reference model

module tb_bwt_extend;

	timeunit 1ns;
	timeprecision 1ps;

	`include "bwt_extend_model.svh"

	localparam int N_ITEMS = 400;
	localparam int MAX_ITEMS = N_ITEMS + 16;
	// primary and l2 enter the merge together with the counts
	localparam int SIDE_COUNT = 7;
	localparam int DONE_COUNT = 12;
	// about one edge in four stalls so twice the unstalled length leaves room
	localparam int TIMEOUT_CYCLES = 2 * (N_ITEMS + DONE_COUNT);

	logic Clk_32UI = 1'b0;
	logic reset_BWT_extend = 1'b0;
	logic stall = 1'b0;
	// non-bubble tag while reset is held
	bwt_pkg::status_t status = 6'h3f;
	bwt_pkg::bwt_pos_t primary = '0;
	bwt_pkg::bwt_pos_t k = '0;
	bwt_pkg::bwt_pos_t l = '0;
	bwt_pkg::occ_t occ_base_k [bwt_pkg::N_SYM] = '{default: '0};
	bwt_pkg::occ_t occ_base_l [bwt_pkg::N_SYM] = '{default: '0};
	bwt_pkg::bwt_word_t occ_words_k [bwt_pkg::N_SYM] = '{default: '0};
	bwt_pkg::bwt_word_t occ_words_l [bwt_pkg::N_SYM] = '{default: '0};
	bwt_pkg::bwt_pos_t l2 [bwt_pkg::N_SYM] = '{default: '0};
	bwt_pkg::bwt_pos_t ik_x0 = '0;
	bwt_pkg::bwt_pos_t ik_x1 = '0;
	bwt_pkg::bwt_pos_t ik_x2 = '0;
	bwt_pkg::sym_t query = '0;

	bwt_pkg::bwt_pos_t ok_x0 [bwt_pkg::N_SYM];
	bwt_pkg::bwt_pos_t ok_x1 [bwt_pkg::N_SYM];
	bwt_pkg::bwt_pos_t ok_x2 [bwt_pkg::N_SYM];
	bwt_pkg::bwt_pos_t ok_target_x0;
	bwt_pkg::bwt_pos_t ok_target_x1;
	bwt_pkg::bwt_pos_t ok_target_x2;
	bwt_pkg::status_t status_out;

	// late inputs and expected results per item
	bwt_pkg::bwt_pos_t prim_item [MAX_ITEMS];
	bwt_pkg::bwt_pos_t l2_item [MAX_ITEMS][bwt_pkg::N_SYM];
	bwt_pkg::sym_t qry_item [MAX_ITEMS];
	bwt_pkg::status_t exp_st [MAX_ITEMS];
	bwt_pkg::bwt_pos_t exp_x0 [MAX_ITEMS][bwt_pkg::N_SYM];
	bwt_pkg::bwt_pos_t exp_x1 [MAX_ITEMS][bwt_pkg::N_SYM];
	bwt_pkg::bwt_pos_t exp_x2 [MAX_ITEMS][bwt_pkg::N_SYM];
	int adv_cnt [MAX_ITEMS];
	// items in flight with the oldest first
	int pending [$];

	// outputs seen at the last edge
	bwt_pkg::bwt_pos_t snap_x0 [bwt_pkg::N_SYM];
	bwt_pkg::bwt_pos_t snap_x1 [bwt_pkg::N_SYM];
	bwt_pkg::bwt_pos_t snap_x2 [bwt_pkg::N_SYM];
	bwt_pkg::bwt_pos_t snap_t0;
	bwt_pkg::bwt_pos_t snap_t1;
	bwt_pkg::bwt_pos_t snap_t2;
	bwt_pkg::status_t snap_st;
	bit have_snap = 1'b0;
	bit prev_stalled = 1'b0;

	int seed = 32'hd41e_3dd1;
	int next_id = 0;
	int checked = 0;
	int mismatches = 0;
	int other_errors = 0;
	int cycles = 0;
	int reset_cycles = 0;
	bit finished = 1'b0;

	bwt_extend UUT (.*);

	always #2 Clk_32UI = ~Clk_32UI;

	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp) else begin
			mismatches++;
			$display("mismatch at %0t ns: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	// ----------------------------------------
	// stimulus
	// ----------------------------------------

	// stage-1 inputs are driven now and the rest is kept for later
	task automatic make_item(input int id);
		logic [255:0] blk_k;
		logic [255:0] blk_l;
		bwt_pkg::occ_t base_k [bwt_pkg::N_SYM];
		bwt_pkg::occ_t base_l [bwt_pkg::N_SYM];
		bwt_pkg::bwt_pos_t kv;
		bwt_pkg::bwt_pos_t lv;
		bwt_pkg::bwt_pos_t x0;
		bwt_pkg::bwt_pos_t x1;
		bwt_pkg::bwt_pos_t x2;
		bwt_pkg::occ_t ck;
		bwt_pkg::occ_t cl;
		kv = {$random(seed), $random(seed)};
		lv = {$random(seed), $random(seed)};
		x0 = {$random(seed), $random(seed)};
		x1 = {33'd0, 31'($random(seed))} + 64'd1;
		x2 = (id % 7 == 3) ? 64'd0 : {48'd0, 16'($random(seed))};
		for (int i = 0; i < bwt_pkg::N_SYM; i++) begin
			blk_k[64*i +: 64] = {$random(seed), $random(seed)};
			blk_l[64*i +: 64] = {$random(seed), $random(seed)};
			base_k[i] = $random(seed);
			base_l[i] = $random(seed);
			occ_words_k[i] <= blk_k[64*i +: 64];
			occ_words_l[i] <= blk_l[64*i +: 64];
			occ_base_k[i] <= base_k[i];
			occ_base_l[i] <= base_l[i];
			l2_item[id][i] = {$random(seed), $random(seed)};
		end
		// sentinel inside, on either edge, just outside, or anywhere
		case (id % 6)
			0: prim_item[id] = x1 + ((x2 == 0) ? 64'd0 : ({48'd0, 16'($random(seed))} % x2));
			1: prim_item[id] = x1;
			2: prim_item[id] = x1 + x2 - 64'd1;
			3: prim_item[id] = x1 - 64'd1;
			4: prim_item[id] = x1 + x2;
			default: prim_item[id] = {$random(seed), $random(seed)};
		endcase
		qry_item[id] = 2'($random(seed));
		exp_st[id] = 6'($random(seed));
		k <= kv;
		l <= lv;
		ik_x0 <= x0;
		ik_x1 <= x1;
		ik_x2 <= x2;
		status <= exp_st[id];
		for (int c = 0; c < bwt_pkg::N_SYM; c++) begin
			ck = count_occ(blk_k, base_k[c], kv, c);
			cl = count_occ(blk_l, base_l[c], lv, c);
			exp_x2[id][c] = extend_x2(cl, ck);
			exp_x1[id][c] = extend_x1(l2_item[id][c], ck);
		end
		exp_x0[id][3] = x0 + (holds_primary(x1, x2, prim_item[id]) ? 64'd1 : 64'd0);
		// each lower symbol starts where the one above ends
		for (int c = 2; c >= 0; c--) begin
			exp_x0[id][c] = exp_x0[id][c+1] + exp_x2[id][c+1];
		end
	endtask

	// noise on every data input while the DUT is stalled
	task automatic scramble_inputs();
		k <= {$random(seed), $random(seed)};
		l <= {$random(seed), $random(seed)};
		ik_x0 <= {$random(seed), $random(seed)};
		ik_x1 <= {$random(seed), $random(seed)};
		ik_x2 <= {$random(seed), $random(seed)};
		primary <= {$random(seed), $random(seed)};
		status <= 6'($random(seed));
		query <= 2'($random(seed));
		for (int i = 0; i < bwt_pkg::N_SYM; i++) begin
			occ_words_k[i] <= {$random(seed), $random(seed)};
			occ_words_l[i] <= {$random(seed), $random(seed)};
			occ_base_k[i] <= $random(seed);
			occ_base_l[i] <= $random(seed);
			l2[i] <= {$random(seed), $random(seed)};
		end
	endtask

	task automatic drive_next();
		bit st;
		st = (($random(seed) & 3) == 0);
		stall <= st;
		if (st) begin
			scramble_inputs();
		end else begin
			make_item(next_id);
			foreach (pending[i]) begin
				if (adv_cnt[pending[i]] == SIDE_COUNT) begin
					primary <= prim_item[pending[i]];
					for (int c = 0; c < bwt_pkg::N_SYM; c++) begin
						l2[c] <= l2_item[pending[i]][c];
					end
				end
				if (adv_cnt[pending[i]] == DONE_COUNT - 1) begin
					query <= qry_item[pending[i]];
				end
			end
		end
	endtask

	// stall as seen by the DUT on this edge
	task automatic advance_pipeline();
		if (!stall) begin
			foreach (pending[i]) begin
				adv_cnt[pending[i]]++;
			end
			pending.push_back(next_id);
			adv_cnt[next_id] = 1;
			next_id++;
		end
		prev_stalled = stall;
	endtask

	// ----------------------------------------
	// checks
	// ----------------------------------------

	task automatic check_outputs();
		int id;
		int t;
		if (have_snap && prev_stalled) begin
			for (int c = 0; c < bwt_pkg::N_SYM; c++) begin
				check_val($sformatf("ok_x0[%0d] held", c), ok_x0[c], snap_x0[c]);
				check_val($sformatf("ok_x1[%0d] held", c), ok_x1[c], snap_x1[c]);
				check_val($sformatf("ok_x2[%0d] held", c), ok_x2[c], snap_x2[c]);
			end
			check_val("ok_target_x0 held", ok_target_x0, snap_t0);
			check_val("ok_target_x1 held", ok_target_x1, snap_t1);
			check_val("ok_target_x2 held", ok_target_x2, snap_t2);
			check_val("status_out held", 64'(status_out), 64'(snap_st));
		end
		if (pending.size() > 0 && adv_cnt[pending[0]] == DONE_COUNT) begin
			id = pending.pop_front();
			// query 0 selects symbol 3
			t = 3 - int'(qry_item[id]);
			for (int c = 0; c < bwt_pkg::N_SYM; c++) begin
				check_val($sformatf("item %0d ok_x0[%0d]", id, c), ok_x0[c], exp_x0[id][c]);
				check_val($sformatf("item %0d ok_x1[%0d]", id, c), ok_x1[c], exp_x1[id][c]);
				check_val($sformatf("item %0d ok_x2[%0d]", id, c), ok_x2[c], exp_x2[id][c]);
			end
			check_val($sformatf("item %0d ok_target_x0", id), ok_target_x0, exp_x0[id][t]);
			check_val($sformatf("item %0d ok_target_x1", id), ok_target_x1, exp_x1[id][t]);
			check_val($sformatf("item %0d ok_target_x2", id), ok_target_x2, exp_x2[id][t]);
			check_val($sformatf("item %0d status_out", id), 64'(status_out), 64'(exp_st[id]));
			checked++;
		end else if (checked == 0) begin
			// bubble tag until the first item is out
			check_val("status_out before first item", 64'(status_out), 64'd0);
		end
		snap_x0 = ok_x0;
		snap_x1 = ok_x1;
		snap_x2 = ok_x2;
		snap_t0 = ok_target_x0;
		snap_t1 = ok_target_x1;
		snap_t2 = ok_target_x2;
		snap_st = status_out;
		have_snap = 1'b1;
	endtask

	always @(posedge Clk_32UI) begin
		if (reset_cycles < 2) begin
			reset_cycles++;
			if (reset_cycles == 2) begin
				reset_BWT_extend <= 1'b1;
				drive_next();
			end
		end else if (!finished) begin
			cycles++;
			check_outputs();
			advance_pipeline();
			drive_next();
			if (checked == N_ITEMS || cycles >= TIMEOUT_CYCLES) begin
				finished = 1'b1;
			end
		end
	end

	initial begin
		wait (finished);
		if (checked < N_ITEMS) begin
			other_errors++;
			$display("timeout after %0d cycles, only %0d of %0d items came out",
				cycles, checked, N_ITEMS);
		end
		$display("%0d items checked, %0d mismatches, %0d other errors",
			checked, mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

/* tb.f */
+incdir+dv
hw/bwt_pkg.sv
hw/interval_if.sv
hw/bwt_occ4.sv
hw/interval_delay.sv
hw/interval_merge.sv
hw/bwt_extend.sv
dv/tb_bwt_extend.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the BWT extension testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--timescale 1ns/1ps \
	--top-module tb_bwt_extend \
	-f tb.f \
	-o sim_bwt_extend

./obj_dir/sim_bwt_extend | tee sim.log

if grep -q ">>> FAIL" sim.log; then
	echo "simulation reported errors"
	exit 1
fi
echo "simulation finished cleanly"
